// File: verilog/fp_format_pkg.sv
`default_nettype none

// ieee 754 binary32 layout
package fp_format_pkg;

  // whole word, sign | exponent | fraction
  typedef logic [31:0] fp32_t;

  typedef logic [7:0]  fp_exp_t;   // biased exponent
  typedef logic [22:0] fp_frac_t;  // stored fraction
  typedef logic [23:0] fp_sig_t;   // fraction with hidden one
  typedef logic [47:0] fp_prod_t;  // 24x24 significand product

  // wide enough for exponent sums below 0 and above 255
  typedef logic signed [9:0] fp_wexp_t;

  localparam fp_exp_t exp_bias     = 8'd127;
  localparam fp_exp_t exp_all_ones = 8'd255;

  // canonical quiet nans
  localparam fp32_t qnan_pos = 32'h7fc0_0000;
  localparam fp32_t qnan_neg = 32'hffc0_0000;

endpackage

`default_nettype wire

// File: verilog/fp_mul_pkg.sv
`default_nettype none

package fp_mul_pkg;

  // 0 nearest-even, 1 toward zero
  typedef logic rnd_mode_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

  typedef struct packed {
    fp_format_pkg::fp32_t a;
    fp_format_pkg::fp32_t b;
    rnd_mode_t            rnd;
  } fp_mul_req_t;

  typedef struct packed {
    fp_format_pkg::fp32_t result;
    fp_flags_t            flags;
  } fp_mul_rsp_t;

  // stage 1 special-case outcome, hit overrides the arithmetic path
  typedef struct packed {
    logic                 hit;
    fp_format_pkg::fp32_t result;
    logic                 invalid;
  } fp_special_t;

  typedef struct packed {
    logic                    sign;
    fp_format_pkg::fp_wexp_t exp_sum;  // already unbiased once
    fp_format_pkg::fp_prod_t prod;
    rnd_mode_t               rnd;
  } fp_prod_t_s;

endpackage

`default_nettype wire

// File: verilog/fp_special_path.sv
`timescale 1ns/1ps
`default_nettype none

module fp_special_path (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load,
  input  fp_mul_pkg::fp_mul_req_t req,
  output fp_mul_pkg::fp_special_t special
);
  import fp_format_pkg::*;
  import fp_mul_pkg::*;

  typedef struct packed {
    logic nan;
    logic inf;
    logic zero;
  } fp_class_t;

  fp_class_t   cls_a;
  fp_class_t   cls_b;
  logic        sign_x;
  fp_special_t special_next;

  function automatic fp_class_t classify(input fp32_t x);
    fp_class_t c;
    c.nan  = (x[30:23] == exp_all_ones) && (x[22:0] != '0);
    c.inf  = (x[30:23] == exp_all_ones) && (x[22:0] == '0);
    c.zero = (x[30:23] == '0);  // subnormals count as zero
    return c;
  endfunction

  always_comb begin
    cls_a  = classify(req.a);
    cls_b  = classify(req.b);
    sign_x = req.a[31] ^ req.b[31];

    special_next     = '0;
    special_next.hit = 1'b1;
    // priority order matters here
    if (cls_a.nan || cls_b.nan) begin
      special_next.result  = qnan_pos;
      special_next.invalid = 1'b1;
    end else if ((cls_a.inf && cls_b.zero) || (cls_b.inf && cls_a.zero)) begin
      special_next.result  = qnan_neg;
      special_next.invalid = 1'b1;
    end else if (cls_a.inf || cls_b.inf) begin
      special_next.result = {sign_x, exp_all_ones, fp_frac_t'(0)};
    end else if (cls_a.zero || cls_b.zero) begin
      special_next.result = {sign_x, 31'd0};
    end else begin
      special_next.hit = 1'b0;  // ordinary operands
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      special <= '0;
    end else if (load) begin
      special <= special_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fp_mant_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mant_mul (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load,
  input  fp_mul_pkg::fp_mul_req_t req,
  output fp_mul_pkg::fp_prod_t_s  prod
);
  import fp_format_pkg::*;
  import fp_mul_pkg::*;

  fp_exp_t    exp_a;
  fp_exp_t    exp_b;
  fp_sig_t    sig_a;
  fp_sig_t    sig_b;
  fp_prod_t_s prod_next;

  always_comb begin
    exp_a = req.a[30:23];
    exp_b = req.b[30:23];
    // hidden one always set, zero and subnormal go the special path
    sig_a = {1'b1, req.a[22:0]};
    sig_b = {1'b1, req.b[22:0]};

    prod_next.sign    = req.a[31] ^ req.b[31];
    prod_next.exp_sum = fp_wexp_t'({2'b00, exp_a})
                      + fp_wexp_t'({2'b00, exp_b})
                      - fp_wexp_t'({2'b00, exp_bias});
    prod_next.prod    = sig_a * sig_b;  // 48 bit, top bit may be 1x.xx
    prod_next.rnd     = req.rnd;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod <= '0;
    end else if (load) begin
      prod <= prod_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fp_round_pack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_round_pack (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  output logic                    load,
  input  fp_mul_pkg::fp_special_t special,
  input  fp_mul_pkg::fp_prod_t_s  prod,
  output logic                    out_valid,
  input  logic                    out_ready,
  output fp_mul_pkg::fp_mul_rsp_t rsp
);
  import fp_format_pkg::*;
  import fp_mul_pkg::*;

  logic        s1_valid;
  logic        s2_ready;
  logic        s2_load;

  logic        norm_shift;
  fp_prod_t    norm;
  fp_sig_t     sig;
  logic        guard_bit;
  logic        round_bit;
  logic        sticky_bit;
  logic        round_up;
  logic [24:0] sig_rnd;
  fp_wexp_t    exp_fin;
  fp_frac_t    frac_fin;
  logic        ovf;
  logic        unf;
  fp_mul_rsp_t rsp_next;

  assign s2_ready = out_ready || !out_valid;
  assign in_ready = s2_ready || !s1_valid;
  assign load     = in_valid && in_ready;
  assign s2_load  = s1_valid && s2_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (load) begin
        s1_valid <= 1'b1;
      end else if (s2_ready) begin
        s1_valid <= 1'b0;  // drained into stage 2
      end

      if (s2_load) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_comb begin
    // product is 01.x or 1x.x, bring the leading one to bit 47
    norm_shift = prod.prod[47];
    norm       = norm_shift ? prod.prod : prod.prod << 1;

    sig        = norm[47:24];
    guard_bit  = norm[23];
    round_bit  = norm[22];
    sticky_bit = |norm[21:0];

    // rnd 0 is nearest-even, toward zero just truncates
    round_up = (prod.rnd == 1'b0) && guard_bit && (round_bit || sticky_bit || sig[0]);
    sig_rnd  = {1'b0, sig} + 25'(round_up);

    exp_fin  = prod.exp_sum
             + fp_wexp_t'({9'd0, norm_shift})
             + fp_wexp_t'({9'd0, sig_rnd[24]});
    frac_fin = sig_rnd[24] ? sig_rnd[23:1] : sig_rnd[22:0];

    ovf = exp_fin >= fp_wexp_t'({2'b00, exp_all_ones});
    unf = exp_fin <= fp_wexp_t'(0);

    rsp_next = '0;
    if (special.hit) begin
      rsp_next.result        = special.result;
      rsp_next.flags.invalid = special.invalid;
    end else begin
      rsp_next.flags.inexact = guard_bit || round_bit || sticky_bit;
      if (ovf) begin
        rsp_next.result         = {prod.sign, exp_all_ones, fp_frac_t'(0)};
        rsp_next.flags.overflow = 1'b1;
        rsp_next.flags.inexact  = 1'b1;
      end else if (unf) begin
        // flush to zero, no subnormal results
        rsp_next.result          = {prod.sign, 31'd0};
        rsp_next.flags.underflow = 1'b1;
        rsp_next.flags.inexact   = 1'b1;
      end else begin
        rsp_next.result = {prod.sign, exp_fin[7:0], frac_fin};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s2_load) begin
      rsp <= rsp_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fp_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

// two-stage binary32 multiplier with valid/ready on both sides
module fp_mul_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  fp_mul_pkg::fp_mul_req_t req,
  output logic                    out_valid,
  input  logic                    out_ready,
  output fp_mul_pkg::fp_mul_rsp_t rsp
);
  import fp_mul_pkg::*;

  logic        load;     // stage 1 capture strobe
  fp_special_t special;
  fp_prod_t_s  prod;

  fp_special_path i_special (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .req     (req),
    .special (special)
  );

  fp_mant_mul i_mant_mul (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .req   (req),
    .prod  (prod)
  );

  fp_round_pack i_round_pack (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .load      (load),
    .special   (special),
    .prod      (prod),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

// File: verif/fp_mul_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mul_sva (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    in_valid,
  input logic                    in_ready,
  input logic                    out_valid,
  input logic                    out_ready,
  input fp_mul_pkg::fp_mul_rsp_t rsp
);

  logic [1:0] in_flight;  // accepted, not yet delivered

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 2'd0;
    end else begin
      in_flight <= in_flight + 2'(in_valid && in_ready) - 2'(out_valid && out_ready);
    end
  end

  // stalled output keeps its data
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(rsp))
    else $error("rsp or out_valid changed while the sink stalled");

  // input stalls only with both stages full and the sink stalled
  a_in_ready: assert property (@(posedge clk) disable iff (!rst_n)
    in_ready == !(in_flight == 2'd2 && !out_ready))
    else $error("in_ready does not match the number of items in flight");

  a_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind fp_mul_top fp_mul_sva i_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .rsp       (rsp)
);

`default_nettype wire

// File: verif/tb_fp_mul.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_mul;
  import fp_format_pkg::*;
  import fp_mul_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  logic        out_valid;
  logic        out_ready;
  fp_mul_req_t req;
  fp_mul_rsp_t rsp;
  logic [31:0] lfsr_state;

  fp_mul_req_t stim_q[$];
  string       stim_name_q[$];
  fp_mul_rsp_t exp_q[$];      // responses still owed by the dut
  string       exp_name_q[$];
  int          acc_cyc_q[$];

  fp_mul_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .req       (req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // exponent 64..191, mostly stays in range
  function automatic fp32_t rand_normal();
    return {1'(rand_bits(1)), 8'(8'd64 + 8'(rand_bits(7))), 23'(rand_bits(23))};
  endfunction

  // expected response straight from the multiply rule
  function automatic fp_mul_rsp_t model(input fp_mul_req_t r);
    fp_mul_rsp_t     m;
    logic            s;
    int              ea, eb, e;
    longint unsigned p, keep, rest;
    bit              nan, inf, zero;
    m    = '0;
    s    = r.a[31] ^ r.b[31];
    ea   = r.a[30:23];
    eb   = r.b[30:23];
    nan  = (ea == 255 && r.a[22:0] != 0) || (eb == 255 && r.b[22:0] != 0);
    inf  = (ea == 255 && r.a[22:0] == 0) || (eb == 255 && r.b[22:0] == 0);
    zero = (ea == 0) || (eb == 0);
    if (nan) begin
      m.result        = qnan_pos;
      m.flags.invalid = 1'b1;
    end else if (inf && zero) begin
      m.result        = qnan_neg;
      m.flags.invalid = 1'b1;
    end else if (inf) begin
      m.result = {s, 8'hff, 23'd0};
    end else if (zero) begin
      m.result = {s, 31'd0};
    end else begin
      p = {40'd0, 1'b1, r.a[22:0]} * {40'd0, 1'b1, r.b[22:0]};
      e = ea + eb - 127;
      if (p[47]) begin
        e = e + 1;
      end else begin
        p = p << 1;
      end
      keep            = p >> 24;
      rest            = p[23:0];
      m.flags.inexact = (rest != 0);
      // ties go to the even neighbour
      if (!r.rnd && (rest > 64'h80_0000 || (rest == 64'h80_0000 && keep[0]))) begin
        keep = keep + 1;
      end
      if (keep[24]) begin
        keep = keep >> 1;
        e    = e + 1;
      end
      if (e >= 255) begin
        m.result         = {s, 8'hff, 23'd0};
        m.flags.overflow = 1'b1;
        m.flags.inexact  = 1'b1;
      end else if (e <= 0) begin
        m.result          = {s, 31'd0};
        m.flags.underflow = 1'b1;
        m.flags.inexact   = 1'b1;
      end else begin
        m.result = {s, e[7:0], keep[22:0]};
      end
    end
    return m;
  endfunction

  task automatic add_item(input string nm, input fp32_t a, input fp32_t b, input rnd_mode_t rnd);
    fp_mul_req_t r;
    r.a   = a;
    r.b   = b;
    r.rnd = rnd;
    stim_q.push_back(r);
    stim_name_q.push_back(nm);
  endtask

  // pushes stim_q through the dut, checks each response in order
  task automatic run_queue(input bit backpressure);
    int          cyc;
    int          idle;
    int          t;
    bit          took;
    string       cur_name;
    string       nm;
    fp_mul_rsp_t want;
    cyc  = 0;
    idle = 0;
    took = 1'b1;
    while (stim_q.size() != 0 || exp_q.size() != 0 || in_valid) begin
      if (took) begin
        in_valid = (stim_q.size() != 0);
        if (in_valid) begin
          req      = stim_q.pop_front();
          cur_name = stim_name_q.pop_front();
        end
      end
      out_ready = backpressure ? 1'(rand_bits(1)) : 1'b1;
      @(posedge clk);
      cyc  = cyc + 1;
      took = in_valid && in_ready;
      if (took) begin
        exp_q.push_back(model(req));
        exp_name_q.push_back(cur_name);
        acc_cyc_q.push_back(cyc);
      end
      if (out_valid && out_ready) begin
        idle = 0;
        if (exp_q.size() == 0) begin
          stop_on_error("response arrived with nothing outstanding");
        end
        want = exp_q.pop_front();
        nm   = exp_name_q.pop_front();
        t    = acc_cyc_q.pop_front();
        assert (rsp === want) else
          stop_on_error($sformatf("Mismatch %s: expected %h actual %h", nm, want, rsp));
        assert (backpressure || cyc - t == 2) else
          stop_on_error($sformatf("Mismatch %s latency: expected 2 actual %0d", nm, cyc - t));
      end else begin
        idle = idle + 1;
        if (idle > 64) begin
          stop_on_error("timeout, no response within 64 cycles");
        end
      end
      @(negedge clk);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    out_ready  = 1'b1;
    req        = '0;
    lfsr_state = 32'hef27_43c9;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!out_valid && in_ready) else
      stop_on_error($sformatf("Mismatch reset: expected %b actual %b", 2'b01,
                              {out_valid, in_ready}));

    add_item("exact", 32'h3fc0_0000, 32'hc000_0000, 1'b0);  // 1.5 * -2.0
    add_item("exact", 32'h4040_0000, 32'h3f00_0000, 1'b1);
    run_queue(1'b0);

    for (int i = 0; i < 40; i++) begin
      add_item("random_rne", rand_normal(), rand_normal(), 1'b0);
      add_item("random_rtz", rand_normal(), rand_normal(), 1'b1);
    end
    run_queue(1'b0);

    add_item("special_nan", 32'h7f80_0001, 32'h3f80_0000, 1'b0);
    add_item("special_nan", 32'h7fc0_0000, 32'h0000_0000, 1'b0);
    add_item("special_inf_zero", 32'hff80_0000, 32'h0000_0000, 1'b0);
    add_item("special_inf_zero", 32'h8000_0001, 32'h7f80_0000, 1'b0);
    add_item("special_inf", 32'h7f80_0000, 32'hc000_0000, 1'b0);
    add_item("special_zero", 32'h8000_0000, 32'h4040_0000, 1'b0);
    add_item("special_subnormal", 32'h0040_0000, 32'h4000_0000, 1'b0);
    add_item("overflow", 32'h7f00_0000, 32'h7f00_0000, 1'b0);
    add_item("overflow", 32'hff00_0000, 32'h4000_0000, 1'b1);
    add_item("underflow", 32'h0080_0000, 32'h0080_0000, 1'b0);
    add_item("underflow", 32'h8080_0000, 32'h3f00_0000, 1'b1);  // lands on exponent 0
    run_queue(1'b0);

    for (int i = 0; i < 60; i++) begin
      add_item("backpressure", rand_normal(), rand_normal(), 1'(rand_bits(1)));
    end
    run_queue(1'b1);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
verilog/fp_format_pkg.sv
verilog/fp_mul_pkg.sv
verilog/fp_special_path.sv
verilog/fp_mant_mul.sv
verilog/fp_round_pack.sv
verilog/fp_mul_top.sv
verif/fp_mul_sva.sv
verif/tb_fp_mul.sv

// File: Bender.yml
package:
  name: fp_mul

sources:
  - files:
      - verilog/fp_format_pkg.sv
      - verilog/fp_mul_pkg.sv
      - verilog/fp_special_path.sv
      - verilog/fp_mant_mul.sv
      - verilog/fp_round_pack.sv
      - verilog/fp_mul_top.sv
  - target: simulation
    files:
      - verif/fp_mul_sva.sv
      - verif/tb_fp_mul.sv
